//--- common/rgmii_rx_pkg.sv
package rgmii_rx_pkg;

    ////////////////////
    // link status
    ////////////////////

    // speed field of the in-band status nibble
    typedef enum logic [1:0] {
        speed_10   = 2'd0,
        speed_100  = 2'd1,
        speed_1000 = 2'd2,
        speed_none = 2'd3
    } link_speed_e;

    // bit positions inside the idle nibble
    localparam int unsigned idle_up_bit     = 0;
    localparam int unsigned idle_speed_lsb  = 1;
    localparam int unsigned idle_duplex_bit = 3;

    ////////////////////
    // register map
    ////////////////////

    typedef enum logic [7:0] {
        reg_ctrl       = 8'h00, // enable and counter clear
        reg_status     = 8'h04, // speed duplex link up
        reg_frames     = 8'h08,
        reg_err_frames = 8'h0c,
        reg_drops      = 8'h10
    } reg_addr_e;

    localparam int unsigned cnt_width = 32;

    // one entry of the rx_clk to clk125MHz FIFO
    typedef struct packed {
        logic [7:0] data;
        logic       dv;
        logic       er;
    } fifo_word_t;

endpackage

//--- hw/rgmii_ddr_capture.sv
`timescale 1ns/10ps

module rgmii_ddr_capture (
    input  logic       rx_clk,
    input  logic       rx_ctl,
    input  logic [3:0] rx_data,
    output logic [7:0] cap_data,
    output logic       cap_dv,
    output logic       cap_er
);

    logic [3:0] rise_data; // low nibble
    logic       rise_ctl;  // rx_dv
    logic [3:0] fall_data; // high nibble
    logic       fall_ctl;  // rx_dv xor rx_er

    ////////////////////
    // ddr sampling
    ////////////////////

    always_ff @(posedge rx_clk) begin
        rise_data <= rx_data;
        rise_ctl  <= rx_ctl;
    end

    always_ff @(negedge rx_clk) begin
        fall_data <= rx_data;
        fall_ctl  <= rx_ctl;
    end

    ////////////////////
    // byte assembly
    ////////////////////

    // rise_* still holds the previous rising edge here
    always_ff @(posedge rx_clk) begin
        cap_data <= {fall_data, rise_data}; // falling nibble on top
        cap_dv   <= rise_ctl;
        cap_er   <= rise_ctl ^ fall_ctl;    // rgmii error encoding
    end

endmodule

//--- hw/rgmii_inband_status.sv
`timescale 1ns/10ps

module rgmii_inband_status (
    input  logic                      rx_clk,
    input  logic                      rst,
    input  logic [7:0]                cap_data,
    input  logic                      cap_dv,
    input  logic                      cap_er,
    output rgmii_rx_pkg::link_speed_e link_speed,
    output logic                      link_full_duplex,
    output logic                      link_up
);

    import rgmii_rx_pkg::*;

    logic [3:0] nibble;
    logic       idle_match; // inter-frame byte with equal nibbles

    assign nibble     = cap_data[3:0];
    assign idle_match = !cap_dv && !cap_er && (cap_data[3:0] == cap_data[7:4]);

    always_ff @(posedge rx_clk) begin
        if (rst) begin
            link_speed       <= speed_none;
            link_full_duplex <= 1'b0;
            link_up          <= 1'b0;
        end else if (idle_match) begin
            link_up          <= nibble[idle_up_bit];
            link_speed       <= link_speed_e'(nibble[idle_speed_lsb +: 2]); // 3 maps to none
            link_full_duplex <= nibble[idle_duplex_bit];
        end
    end

endmodule

//--- rx_fifo/rx_cdc_fifo.sv
`timescale 1ns/10ps

module rx_cdc_fifo #(
    parameter int fifo_addr_width = 4
) (
    input  logic                     rx_clk,
    input  logic                     clk125MHz,
    input  logic                     rst,
    input  rgmii_rx_pkg::fifo_word_t wr_word,
    input  logic                     rd_en,
    output rgmii_rx_pkg::fifo_word_t rd_word,
    output logic                     rd_empty,
    output logic [fifo_addr_width:0] rd_level,
    output logic                     wr_drop_pulse
);

    import rgmii_rx_pkg::*;

    localparam int depth = 1 << fifo_addr_width;

    fifo_word_t mem [0:depth-1];

    logic                     wr_rst_meta;
    logic                     wr_rst;      // rst in the rx_clk domain
    logic [fifo_addr_width:0] wr_bin;
    logic [fifo_addr_width:0] wr_gray;
    logic [fifo_addr_width:0] rd_gray_meta;
    logic [fifo_addr_width:0] rd_gray_sync;
    logic                     wr_full;
    logic                     drop_toggle;

    logic [fifo_addr_width:0] rd_bin;
    logic [fifo_addr_width:0] rd_gray;
    logic [fifo_addr_width:0] wr_gray_meta;
    logic [fifo_addr_width:0] wr_gray_sync;
    logic                     drop_meta;
    logic                     drop_sync;
    logic                     drop_last;
    logic                     rd_take;

    function automatic logic [fifo_addr_width:0] bin2gray(input logic [fifo_addr_width:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [fifo_addr_width:0] gray2bin(input logic [fifo_addr_width:0] g);
        logic [fifo_addr_width:0] b;
        b[fifo_addr_width] = g[fifo_addr_width];
        for (int i = fifo_addr_width - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    ////////////////////
    // write side
    ////////////////////

    always_ff @(posedge rx_clk) begin
        wr_rst_meta <= rst;
        wr_rst      <= wr_rst_meta;
    end

    // full when the top two gray bits differ and the rest match
    assign wr_full = (wr_gray == {~rd_gray_sync[fifo_addr_width -: 2],
                                  rd_gray_sync[fifo_addr_width-2:0]});

    always_ff @(posedge rx_clk) begin
        if (wr_rst) begin
            wr_bin       <= '0;
            wr_gray      <= '0;
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
            drop_toggle  <= 1'b0;
        end else begin
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
            if (wr_full) begin
                drop_toggle <= ~drop_toggle; // word lost
            end else begin
                wr_bin  <= wr_bin + 1'b1;
                wr_gray <= bin2gray(wr_bin + 1'b1);
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (!wr_full) begin
            mem[wr_bin[fifo_addr_width-1:0]] <= wr_word;
        end
    end

    ////////////////////
    // read side
    ////////////////////

    assign rd_take  = rd_en && !rd_empty; // no underflow
    assign rd_empty = (rd_gray == wr_gray_sync);
    assign rd_level = gray2bin(wr_gray_sync) - rd_bin;

    always_ff @(posedge clk125MHz) begin
        if (rst) begin
            rd_bin       <= '0;
            rd_gray      <= '0;
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
            drop_meta    <= 1'b0;
            drop_sync    <= 1'b0;
            drop_last    <= 1'b0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
            drop_meta    <= drop_toggle;
            drop_sync    <= drop_meta;
            drop_last    <= drop_sync;
            if (rd_take) begin
                rd_bin  <= rd_bin + 1'b1;
                rd_gray <= bin2gray(rd_bin + 1'b1);
            end
        end
    end

    always_ff @(posedge clk125MHz) begin
        if (rd_take) begin
            rd_word <= mem[rd_bin[fifo_addr_width-1:0]];
        end
    end

    assign wr_drop_pulse = drop_sync ^ drop_last; // one pulse per toggle

endmodule

//--- rx_fifo/rx_fifo_pacer.sv
`timescale 1ns/10ps

module rx_fifo_pacer #(
    parameter int fifo_addr_width = 4,
    parameter int start_level     = 8
) (
    input  logic                     clk125MHz,
    input  logic                     rst,
    input  logic                     enable,
    input  logic [fifo_addr_width:0] rd_level,
    input  logic                     rd_empty,
    input  rgmii_rx_pkg::fifo_word_t rd_word,
    output logic                     rd_en,
    output logic [7:0]               rx_byte,
    output logic                     rx_valid,
    output logic                     rx_error
);

    typedef enum logic {
        fill,  // wait for start_level
        drain  // read every cycle until empty
    } pacer_state_e;

    pacer_state_e state;
    logic         rd_pending; // rd_word holds a fresh entry

    ////////////////////
    // pacing fsm
    ////////////////////

    always_ff @(posedge clk125MHz) begin
        if (rst) begin
            state      <= fill;
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_en;
            case (state)
                fill:  if (rd_level >= start_level) state <= drain;
                drain: if (rd_empty) state <= fill;
                default: state <= fill;
            endcase
        end
    end

    assign rd_en = (state == drain) && !rd_empty;

    ////////////////////
    // byte output
    ////////////////////

    // idle words and words read while disabled go nowhere
    assign rx_byte  = rd_word.data;
    assign rx_valid = rd_pending && enable && rd_word.dv;
    assign rx_error = rd_pending && enable && rd_word.dv && rd_word.er;

endmodule

//--- hw/rgmii_rx_stats.sv
`timescale 1ns/10ps

module rgmii_rx_stats (
    input  logic                               clk125MHz,
    input  logic                               rst,
    input  logic                               clear,
    input  logic                               rx_valid,
    input  logic                               rx_error,
    input  logic                               wr_drop_pulse,
    output logic [rgmii_rx_pkg::cnt_width-1:0] frame_count,
    output logic [rgmii_rx_pkg::cnt_width-1:0] err_frame_count,
    output logic [rgmii_rx_pkg::cnt_width-1:0] drop_count
);

    logic valid_last; // rx_valid one cycle back
    logic err_seen;   // an error byte in the current frame
    logic frame_end;

    assign frame_end = valid_last && !rx_valid;

    always_ff @(posedge clk125MHz) begin
        if (rst) begin
            valid_last <= 1'b0;
            err_seen   <= 1'b0;
        end else begin
            valid_last <= rx_valid;
            if (frame_end) begin
                err_seen <= 1'b0;
            end else if (rx_valid && rx_error) begin
                err_seen <= 1'b1;
            end
        end
    end

    ////////////////////
    // counters
    ////////////////////

    always_ff @(posedge clk125MHz) begin
        if (rst || clear) begin
            frame_count     <= '0;
            err_frame_count <= '0;
            drop_count      <= '0;
        end else begin
            if (frame_end) begin
                frame_count <= frame_count + 1'b1;
                if (err_seen) begin
                    err_frame_count <= err_frame_count + 1'b1;
                end
            end
            if (wr_drop_pulse) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

endmodule

//--- hw/rgmii_rx_regs.sv
`timescale 1ns/10ps

module rgmii_rx_regs (
    input  logic                               clk125MHz,
    input  logic                               rst,
    input  logic [7:0]                         paddr,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [31:0]                        pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  rgmii_rx_pkg::link_speed_e          link_speed,
    input  logic                               link_full_duplex,
    input  logic                               link_up,
    input  logic [rgmii_rx_pkg::cnt_width-1:0] frame_count,
    input  logic [rgmii_rx_pkg::cnt_width-1:0] err_frame_count,
    input  logic [rgmii_rx_pkg::cnt_width-1:0] drop_count,
    output logic                               enable,
    output logic                               clear
);

    import rgmii_rx_pkg::*;

    link_speed_e speed_meta;
    link_speed_e speed_sync;
    logic        duplex_meta;
    logic        duplex_sync;
    logic        up_meta;
    logic        up_sync;

    logic access;    // apb access phase
    logic addr_hit;  // paddr is a listed register
    logic read_only; // every register but ctrl

    ////////////////////
    // link status sync
    ////////////////////

    always_ff @(posedge clk125MHz) begin
        if (rst) begin
            speed_meta  <= speed_none;
            speed_sync  <= speed_none;
            duplex_meta <= 1'b0;
            duplex_sync <= 1'b0;
            up_meta     <= 1'b0;
            up_sync     <= 1'b0;
        end else begin
            speed_meta  <= link_speed;
            speed_sync  <= speed_meta;
            duplex_meta <= link_full_duplex;
            duplex_sync <= duplex_meta;
            up_meta     <= link_up;
            up_sync     <= up_meta;
        end
    end

    ////////////////////
    // apb decode
    ////////////////////

    assign access    = psel && penable;
    assign read_only = (paddr != reg_ctrl);

    always_comb begin
        addr_hit = 1'b1;
        prdata   = '0;
        case (paddr)
            reg_ctrl:       prdata = {30'd0, 1'b0, enable}; // clear reads back 0
            reg_status:     prdata = {28'd0, up_sync, duplex_sync, speed_sync};
            reg_frames:     prdata = frame_count;
            reg_err_frames: prdata = err_frame_count;
            reg_drops:      prdata = drop_count;
            default:        addr_hit = 1'b0;
        endcase
    end

    assign pready  = access; // never any wait states
    assign pslverr = access && (!addr_hit || (pwrite && read_only));

    ////////////////////
    // control register
    ////////////////////

    always_ff @(posedge clk125MHz) begin
        if (rst) begin
            enable <= 1'b0;
            clear  <= 1'b0;
        end else begin
            clear <= 1'b0; // one cycle pulse
            if (access && pwrite && (paddr == reg_ctrl)) begin
                enable <= pwdata[0];
                clear  <= pwdata[1];
            end
        end
    end

endmodule

//--- hw/rgmii_rx_top.sv
`timescale 1ns/10ps

module rgmii_rx_top #(
    parameter int fifo_addr_width = 4,
    parameter int start_level     = 8
) (
    input  logic        clk125MHz,
    input  logic        rst,
    input  logic        rx_clk,
    input  logic        rx_ctl,
    input  logic [3:0]  rx_data,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [7:0]  rx_byte,
    output logic        rx_valid,
    output logic        rx_error
);

    import rgmii_rx_pkg::*;

    // rx_clk domain
    logic [7:0]  cap_data;
    logic        cap_dv;
    logic        cap_er;
    fifo_word_t  cap_word;
    link_speed_e link_speed;
    logic        link_full_duplex;
    logic        link_up;

    // clk125MHz domain
    fifo_word_t                 rd_word;
    logic                       rd_en;
    logic                       rd_empty;
    logic [fifo_addr_width:0]   rd_level;
    logic                       wr_drop_pulse;
    logic                       enable;
    logic                       clear;
    logic [cnt_width-1:0]       frame_count;
    logic [cnt_width-1:0]       err_frame_count;
    logic [cnt_width-1:0]       drop_count;

    assign cap_word = '{data: cap_data, dv: cap_dv, er: cap_er};

    ////////////////////
    // receive path
    ////////////////////

    rgmii_ddr_capture rgmii_ddr_capture_inst (
        .rx_clk   (rx_clk),
        .rx_ctl   (rx_ctl),
        .rx_data  (rx_data),
        .cap_data (cap_data),
        .cap_dv   (cap_dv),
        .cap_er   (cap_er)
    );

    rgmii_inband_status rgmii_inband_status_inst (
        .rx_clk           (rx_clk),
        .rst              (rst),
        .cap_data         (cap_data),
        .cap_dv           (cap_dv),
        .cap_er           (cap_er),
        .link_speed       (link_speed),
        .link_full_duplex (link_full_duplex),
        .link_up          (link_up)
    );

    rx_cdc_fifo #(
        .fifo_addr_width (fifo_addr_width)
    ) rx_cdc_fifo_inst (
        .rx_clk        (rx_clk),
        .clk125MHz     (clk125MHz),
        .rst           (rst),
        .wr_word       (cap_word),
        .rd_en         (rd_en),
        .rd_word       (rd_word),
        .rd_empty      (rd_empty),
        .rd_level      (rd_level),
        .wr_drop_pulse (wr_drop_pulse)
    );

    rx_fifo_pacer #(
        .fifo_addr_width (fifo_addr_width),
        .start_level     (start_level)
    ) rx_fifo_pacer_inst (
        .clk125MHz (clk125MHz),
        .rst       (rst),
        .enable    (enable),
        .rd_level  (rd_level),
        .rd_empty  (rd_empty),
        .rd_word   (rd_word),
        .rd_en     (rd_en),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .rx_error  (rx_error)
    );

    ////////////////////
    // stats and registers
    ////////////////////

    rgmii_rx_stats rgmii_rx_stats_inst (
        .clk125MHz       (clk125MHz),
        .rst             (rst),
        .clear           (clear),
        .rx_valid        (rx_valid),
        .rx_error        (rx_error),
        .wr_drop_pulse   (wr_drop_pulse),
        .frame_count     (frame_count),
        .err_frame_count (err_frame_count),
        .drop_count      (drop_count)
    );

    rgmii_rx_regs rgmii_rx_regs_inst (
        .clk125MHz        (clk125MHz),
        .rst              (rst),
        .paddr            (paddr),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .link_speed       (link_speed),
        .link_full_duplex (link_full_duplex),
        .link_up          (link_up),
        .frame_count      (frame_count),
        .err_frame_count  (err_frame_count),
        .drop_count       (drop_count),
        .enable           (enable),
        .clear            (clear)
    );

endmodule

//--- verif/rgmii_rx_tb.sv
`timescale 1ns/10ps

module rgmii_rx_tb;

    import rgmii_rx_pkg::*;

    localparam int idle_lead      = 12; // status bytes ahead of each frame
    localparam int idle_trail     = 20; // gap that lets the pipeline drain
    localparam int apb_wait_limit = 16; // cycles allowed for pready
    localparam real rx_phase_ns   = 1.3;

    logic        clk125MHz;
    logic        rst;
    logic        rx_clk;
    logic        rx_ctl;
    logic [3:0]  rx_data;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  rx_byte;
    logic        rx_valid;
    logic        rx_error;

    // frame table, one entry per row
    logic [3:0] row_nib [$]; // idle status nibble
    int         row_len [$];
    int         row_err [$]; // -1 for a clean frame
    bit         row_en  [$];
    bit         table_ready;

    logic [7:0] exp_byte_q [$]; // payload still to come out
    bit         exp_err_q  [$];
    logic [7:0] mon_byte;
    bit         mon_err;

    string cur_test = "reset";
    int    byte_errors;
    int    flag_errors;
    int    status_errors;
    int    count_errors;
    int    other_errors;

    rgmii_rx_top rgmii_rx_top_inst (
        .clk125MHz (clk125MHz),
        .rst       (rst),
        .rx_clk    (rx_clk),
        .rx_ctl    (rx_ctl),
        .rx_data   (rx_data),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .rx_error  (rx_error)
    );

    ////////////////////
    // clocks
    ////////////////////

    initial clk125MHz = 1'b0;
    always #4 clk125MHz = ~clk125MHz;

    initial rx_clk = 1'b0;
    always begin
        #(rx_phase_ns);          // phy clock skewed against the system clock
        forever #4 rx_clk = ~rx_clk;
    end

    ////////////////////
    // frame table
    ////////////////////

    task automatic add_row(input logic [3:0] nib, input int len, input int err, input bit en);
        row_nib.push_back(nib);
        row_len.push_back(len);
        row_err.push_back(err);
        row_en.push_back(en);
    endtask

    task automatic load_frame_table();
        add_row(4'hd, 24, -1, 1'b1); // 1000 full duplex up
        add_row(4'hb, 40, 5, 1'b1);  // 100 full duplex
        add_row(4'h5, 16, -1, 1'b0); // disabled
        add_row(4'h1, 64, 63, 1'b1); // er on the last byte
        add_row(4'h6, 20, 0, 1'b0);  // link down, disabled with er
        add_row(4'hf, 32, 0, 1'b1);  // er on the first byte
        add_row(4'hd, 50, -1, 1'b1);
        add_row(4'h9, 30, 12, 1'b1); // 10 full duplex
        table_ready = 1'b1;
    endtask

    // speed field of the idle nibble, bits 2:1
    function automatic link_speed_e expected_speed(input logic [3:0] nib);
        case (nib[2:1])
            2'd0:    return speed_10;
            2'd1:    return speed_100;
            2'd2:    return speed_1000;
            default: return speed_none;
        endcase
    endfunction

    function automatic int watchdog_ns();
        int total;
        total = 2000;
        foreach (row_len[i]) total += (row_len[i] + idle_lead + idle_trail) * 8;
        return total;
    endfunction

    ////////////////////
    // phy driver
    ////////////////////

    task automatic send_byte(input logic [7:0] b, input logic ctl_rise, input logic ctl_fall);
        @(negedge rx_clk);
        rx_data <= b[3:0];   // taken on the next rising edge
        rx_ctl  <= ctl_rise;
        @(posedge rx_clk);
        rx_data <= b[7:4];   // taken on the falling edge
        rx_ctl  <= ctl_fall;
    endtask

    task automatic send_frame(input int r);
        logic [7:0] b;
        logic [3:0] nib;
        nib = row_nib[r];
        repeat (idle_lead) send_byte({nib, nib}, 1'b0, 1'b0);
        for (int i = 0; i < row_len[r]; i++) begin
            b = 8'($urandom);
            if (row_en[r]) begin
                exp_byte_q.push_back(b);
                exp_err_q.push_back(i == row_err[r]);
            end
            send_byte(b, 1'b1, i != row_err[r]); // ctl low on the falling edge means er
        end
        repeat (idle_trail) send_byte({nib, nib}, 1'b0, 1'b0);
    endtask

    ////////////////////
    // apb master
    ////////////////////

    task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        int waits;
        waits = 0;
        @(posedge clk125MHz);
        psel    <= 1'b1;     // setup phase
        penable <= 1'b0;
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        @(posedge clk125MHz);
        penable <= 1'b1;     // access phase
        @(negedge clk125MHz);
        while (pready !== 1'b1 && waits < apb_wait_limit) begin
            waits++;
            @(negedge clk125MHz);
        end
        if (pready !== 1'b1) begin
            other_errors++;
            $display("%s: no pready from register 0x%02h after %0d cycles", cur_test, addr, waits);
        end else if (waits != 0) begin
            other_errors++;
            $display("%s: pready from register 0x%02h came after %0d wait states",
                     cur_test, addr, waits);
        end
        rdata  = prdata;
        slverr = pslverr;
        @(posedge clk125MHz);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] ignored;
        logic        slverr;
        apb_access(addr, 1'b1, wdata, ignored, slverr);
        check_bit($sformatf("pslverr on write 0x%02h", addr), 1'b0, slverr);
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] rdata);
        logic slverr;
        apb_access(addr, 1'b0, 32'd0, rdata, slverr);
        check_bit($sformatf("pslverr on read 0x%02h", addr), 1'b0, slverr);
    endtask

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            byte_errors++;
            $display("ERROR %s %s: expected 0x%02h actual 0x%02h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_speed(input string what, input link_speed_e exp, input link_speed_e act);
        if (act !== exp) begin
            status_errors++;
            $display("ERROR %s %s: expected %s actual %s", cur_test, what, exp.name(), act.name());
        end
    endtask

    task automatic check_count(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            count_errors++;
            $display("ERROR %s %s: expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errors++;
            $display("ERROR %s %s: expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic show_counts();
        $display("errors: bytes %0d flags %0d status %0d counts %0d other %0d",
                 byte_errors, flag_errors, status_errors, count_errors, other_errors);
    endtask

    ////////////////////
    // byte monitor
    ////////////////////

    // outputs settle well before the falling edge
    always @(negedge clk125MHz) begin
        if (!rst && rx_valid === 1'b1) begin
            if (exp_byte_q.size() == 0) begin
                other_errors++;
                $display("%s: extra byte 0x%02h on rx_byte", cur_test, rx_byte);
            end else begin
                mon_byte = exp_byte_q.pop_front();
                mon_err  = exp_err_q.pop_front();
                check_byte("rx_byte", mon_byte, rx_byte);
                check_bit("rx_error", mon_err, rx_error);
            end
        end else if (!rst && rx_error === 1'b1) begin
            other_errors++;
            $display("%s: rx_error high while rx_valid is low", cur_test);
        end
    end

    ////////////////////
    // watchdog
    ////////////////////

    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = watchdog_ns();
        #(limit_ns);
        $display("watchdog expired after %0d ns in %s, the run did not finish", limit_ns, cur_test);
        show_counts();
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        logic [31:0] rdata;
        logic        slverr;
        logic [3:0]  nib;
        int          exp_frames;
        int          exp_err_frames;
        int          total_errors;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'd0;
        pwdata  = 32'd0;
        rx_ctl  = 1'b0;
        rx_data = 4'd0;
        void'($urandom(97400));
        exp_frames     = 0;
        exp_err_frames = 0;
        load_frame_table();
        repeat (3) @(posedge clk125MHz);
        rst <= 1'b0;
        repeat (4) @(posedge clk125MHz); // rx_clk side leaves reset

        for (int r = 0; r < row_len.size(); r++) begin
            cur_test = $sformatf("frame %0d", r);
            nib      = row_nib[r];
            reg_write(reg_ctrl, {31'd0, row_en[r]});
            send_frame(r);
            if (row_en[r]) begin
                exp_frames++;
                if (row_err[r] >= 0) exp_err_frames++;
            end
            reg_read(reg_status, rdata);
            check_speed("link speed", expected_speed(nib), link_speed_e'(rdata[1:0]));
            check_bit("full duplex", nib[3], rdata[2]);
            check_bit("link up", nib[0], rdata[3]);
            reg_read(reg_frames, rdata);
            check_count("reg_frames", exp_frames, rdata);
            reg_read(reg_err_frames, rdata);
            check_count("reg_err_frames", exp_err_frames, rdata);
            if (exp_byte_q.size() != 0) begin
                other_errors++;
                $display("%s: %0d bytes never came out on rx_byte", cur_test, exp_byte_q.size());
                exp_byte_q.delete();
                exp_err_q.delete();
            end
        end

        cur_test = "overflow";
        reg_read(reg_drops, rdata);
        check_count("reg_drops", 32'd0, rdata); // both clocks run at the same rate

        cur_test = "counter clear";
        reg_write(reg_ctrl, 32'h3);
        reg_read(reg_ctrl, rdata);
        check_count("reg_ctrl", 32'h1, rdata);  // clear bit reads back 0
        reg_read(reg_frames, rdata);
        check_count("reg_frames", 32'd0, rdata);
        reg_read(reg_err_frames, rdata);
        check_count("reg_err_frames", 32'd0, rdata);

        cur_test = "bad access";
        apb_access(8'h20, 1'b0, 32'd0, rdata, slverr);
        check_bit("pslverr on read 0x20", 1'b1, slverr);
        apb_access(reg_status, 1'b1, 32'hf, rdata, slverr);
        check_bit("pslverr on write reg_status", 1'b1, slverr);
        apb_access(reg_frames, 1'b1, 32'h5, rdata, slverr);
        check_bit("pslverr on write reg_frames", 1'b1, slverr);

        total_errors = byte_errors + flag_errors + status_errors + count_errors + other_errors;
        show_counts();
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim.f
common/rgmii_rx_pkg.sv
hw/rgmii_ddr_capture.sv
hw/rgmii_inband_status.sv
rx_fifo/rx_cdc_fifo.sv
rx_fifo/rx_fifo_pacer.sv
hw/rgmii_rx_stats.sv
hw/rgmii_rx_regs.sv
hw/rgmii_rx_top.sv
verif/rgmii_rx_tb.sv
